/* flist.f */
+incdir+source
source/kv_pkg.sv
source/kv_fsm.sv
source/kv_vault.sv
source/kv_client.sv
source/kv_engine.sv
source/kv_top.sv
dv/kv_clk_gen.sv
dv/kv_tb.sv

/* dv/kv_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kv_macros.svh"

module kv_tb;
   import kv_pkg::*;

   localparam int RESET_CYCLES   = 8;
   localparam int PRELOAD_CYCLES = 6 * `KV_ENTRY_DWORDS;
   localparam int NUM_RUNS       = 6;
   localparam int RUN_CYCLES     = 40;
   localparam int CYCLE_LIMIT    =
      2 * (RESET_CYCLES + PRELOAD_CYCLES + NUM_RUNS * RUN_CYCLES + 2 * `KV_ENTRY_DWORDS);

   logic                             clk;
   logic                             rst_n;
   kv_reg_t                          ctrl;
   logic                             host_wr_en;
   kv_entry_idx_t                    host_wr_entry;
   kv_offset_t                       host_wr_offset;
   kv_dword_t                        host_wr_data;
   kv_entry_idx_t                    host_rd_entry;
   kv_offset_t                       host_rd_offset;
   kv_dword_t                        host_rd_data;
   logic                             result_valid;
   kv_dword_t [`KV_ENTRY_DWORDS-1:0] result_data;
   logic                             key_done;
   logic                             src_done;
   logic                             dest_done;

   // reference copy of the vault
   kv_dword_t                  ref_mem [`KV_NUM_ENTRIES][`KV_ENTRY_DWORDS];
   logic [`KV_NUM_ENTRIES-1:0] ref_valid;
   logic [31:0]                lfsr_state;
   int                         err_count;
   int                         check_count;
   int                         cycle_count;

   kv_clk_gen clk_gen0 (.clk(clk));

   kv_top dut0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .ctrl           (ctrl),
      .host_wr_en     (host_wr_en),
      .host_wr_entry  (host_wr_entry),
      .host_wr_offset (host_wr_offset),
      .host_wr_data   (host_wr_data),
      .host_rd_entry  (host_rd_entry),
      .host_rd_offset (host_rd_offset),
      .host_rd_data   (host_rd_data),
      .result_valid   (result_valid),
      .result_data    (result_data),
      .key_done       (key_done),
      .src_done       (src_done),
      .dest_done      (dest_done)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic rand_word(output kv_dword_t w);
      for (int i = 0; i < 32; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         w = {w[30:0], lfsr_state[0]};
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic compare_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      check_count++;
      assert (exp === act) else begin
         err_count++;
         $display("Mismatch %s: expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic expect_true(input string name, input logic cond, input string what);
      check_count++;
      assert (cond === 1'b1) else begin
         err_count++;
         $display("%s: %s", name, what);
      end
   endtask

   // invalid entries read as zero
   function automatic kv_dword_t ref_word(kv_entry_idx_t e, int k);
      return ref_valid[e] ? ref_mem[e][k] : '0;
   endfunction

   // result for offset k, with the pad rule applied past the source size
   function automatic kv_dword_t expected_dword(kv_reg_t c, int k);
      kv_dword_t src;
      if (k < c.src_data_size) begin
         src = ref_word(c.src_sel, k);
      end else if (k == c.src_data_size) begin
         src = `KV_PAD_WORD;
      end else begin
         src = '0;
      end
      return ref_word(c.key_sel, k) ^ src;
   endfunction

   task automatic preload_entry(input kv_entry_idx_t entry);
      kv_dword_t w;
      for (int k = 0; k < `KV_ENTRY_DWORDS; k++) begin
         rand_word(w);
         ref_mem[entry][k] = w;
         host_wr_en     = 1'b1;
         host_wr_entry  = entry;
         host_wr_offset = kv_offset_t'(k);
         host_wr_data   = w;
         next_cycle();
      end
      host_wr_en = 1'b0;
      ref_valid[entry] = 1'b1;
   endtask

   task automatic run_combine(input string name, input kv_entry_idx_t key,
                              input kv_entry_idx_t src, input kv_offset_t size,
                              input logic writeback, input kv_entry_idx_t dest);
      kv_reg_t   c;
      int        waited;
      kv_dword_t exp [`KV_ENTRY_DWORDS];
      c               = '0;
      c.key_sel_en    = 1'b1;
      c.key_sel       = key;
      c.src_sel_en    = 1'b1;
      c.src_sel       = src;
      c.src_data_size = size;
      c.dest_sel_en   = writeback;
      c.dest_sel      = dest;
      c.dest_valid    = writeback;
      ctrl            = c;
      for (int k = 0; k < `KV_ENTRY_DWORDS; k++) begin
         exp[k] = expected_dword(c, k);
      end
      waited = 0;
      while (!(writeback ? dest_done : result_valid) && (waited < RUN_CYCLES)) begin
         next_cycle();
         waited++;
      end
      expect_true(name, waited < RUN_CYCLES, "run did not finish in time");
      compare_value({name, " key_done"}, 1, key_done);
      compare_value({name, " src_done"}, 1, src_done);
      if (!writeback) begin
         for (int k = 0; k < `KV_ENTRY_DWORDS; k++) begin
            compare_value($sformatf("%s dword %0d", name, k), exp[k],
                          result_data[`KV_ENTRY_DWORDS-1-k]);
         end
         // levels hold while the enables stay high
         repeat (4) begin
            next_cycle();
            compare_value({name, " hold result_valid"}, 1, result_valid);
            compare_value({name, " hold key_done"}, 1, key_done);
            compare_value({name, " hold src_done"}, 1, src_done);
         end
      end else begin
         compare_value({name, " result_valid"}, 0, result_valid);
         for (int k = 0; k < `KV_ENTRY_DWORDS; k++) begin
            host_rd_entry  = dest;
            host_rd_offset = kv_offset_t'(k);
            next_cycle();
            compare_value($sformatf("%s readback %0d", name, k), exp[k], host_rd_data);
         end
         compare_value({name, " hold dest_done"}, 1, dest_done);
         for (int k = 0; k < `KV_ENTRY_DWORDS; k++) begin
            ref_mem[dest][k] = exp[k];
         end
         ref_valid[dest] = 1'b1;
      end
   endtask

   // all levels must fall the cycle after the enables drop
   task automatic end_run(input string name);
      ctrl = '0;
      next_cycle();
      compare_value({name, " key_done low"}, 0, key_done);
      compare_value({name, " src_done low"}, 0, src_done);
      compare_value({name, " dest_done low"}, 0, dest_done);
      compare_value({name, " result_valid low"}, 0, result_valid);
      repeat (2) next_cycle();
   endtask

   a_key_done_enabled: assert property (
      @(posedge clk) disable iff (!rst_n)
      key_done |-> $past(ctrl.key_sel_en)
   ) else begin
      err_count++;
      $display("key_done was high without key_sel_en held");
   end

   a_src_done_enabled: assert property (
      @(posedge clk) disable iff (!rst_n)
      src_done |-> $past(ctrl.src_sel_en)
   ) else begin
      err_count++;
      $display("src_done was high without src_sel_en held");
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("simulation stopped after %0d cycles without finishing", cycle_count);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      rst_n          = 1'b0;
      ctrl           = '0;
      host_wr_en     = 1'b0;
      host_wr_entry  = '0;
      host_wr_offset = '0;
      host_wr_data   = '0;
      host_rd_entry  = '0;
      host_rd_offset = '0;
      lfsr_state     = 32'h8d288c90;
      ref_valid      = '0;
      err_count      = 0;
      check_count    = 0;
      cycle_count    = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      compare_value("reset key_done", 0, key_done);
      compare_value("reset src_done", 0, src_done);
      compare_value("reset dest_done", 0, dest_done);
      compare_value("reset result_valid", 0, result_valid);
      compare_value("reset key_write_en", 0, dut0.key_write_en);
      compare_value("reset src_write_en", 0, dut0.src_write_en);
      compare_value("reset dest_wr_vld", 0, dut0.kv_write.dest_wr_vld);
      compare_value("reset dest_data_avail", 0, dut0.dest_data_avail);
      // entries 6 and 7 stay empty
      for (int e = 0; e < 6; e++) begin
         preload_entry(kv_entry_idx_t'(e));
      end
      run_combine("full", 0, 1, 12, 1'b0, 0);
      end_run("full");
      run_combine("padded", 2, 3, 5, 1'b0, 0);
      end_run("padded");
      run_combine("writeback", 4, 5, 12, 1'b1, 6);
      end_run("writeback");
      // entry 7 never loaded, result is the key alone
      run_combine("empty_src", 1, 7, 12, 1'b0, 0);
      end_run("empty_src");
      run_combine("written_key", 6, 0, 12, 1'b0, 0);
      end_run("written_key");
      run_combine("pad_only", 3, 2, 0, 1'b0, 0);
      end_run("pad_only");
      $display("checks %0d errors %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dv/kv_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module kv_clk_gen #(
   parameter int HALF_PERIOD = 4
) (
   output logic clk
);

   // free running, 8 ns period
   initial begin
      clk = 1'b0;
      forever begin
         #(HALF_PERIOD) clk = ~clk;
      end
   end

endmodule

`default_nettype wire

/* source/kv_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kv_macros.svh"

module kv_top (
   input  wire                                      clk,
   input  wire                                      rst_n,
   input  wire kv_pkg::kv_reg_t                     ctrl,
   input  wire                                      host_wr_en,
   input  wire kv_pkg::kv_entry_idx_t               host_wr_entry,
   input  wire kv_pkg::kv_offset_t                  host_wr_offset,
   input  wire kv_pkg::kv_dword_t                   host_wr_data,
   input  wire kv_pkg::kv_entry_idx_t               host_rd_entry,
   input  wire kv_pkg::kv_offset_t                  host_rd_offset,
   output kv_pkg::kv_dword_t                        host_rd_data,
   output logic                                     result_valid,
   output kv_pkg::kv_dword_t [`KV_ENTRY_DWORDS-1:0] result_data,
   output logic                                     key_done,
   output logic                                     src_done,
   output logic                                     dest_done
);
   import kv_pkg::*;

   kv_read_t                         kv_read;
   kv_write_t                        kv_write;
   kv_resp_t                         kv_resp;
   logic                             key_write_en;
   kv_offset_t                       key_write_offset;
   kv_dword_t                        key_write_data;
   logic                             src_write_en;
   kv_offset_t                       src_write_offset;
   kv_dword_t                        src_write_data;
   logic                             dest_keyvault;
   logic                             dest_data_avail;
   kv_dword_t [`KV_ENTRY_DWORDS-1:0] dest_data;

   kv_vault vault0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .host_wr_en     (host_wr_en),
      .host_wr_entry  (host_wr_entry),
      .host_wr_offset (host_wr_offset),
      .host_wr_data   (host_wr_data),
      .host_rd_entry  (host_rd_entry),
      .host_rd_offset (host_rd_offset),
      .host_rd_data   (host_rd_data),
      .kv_read        (kv_read),
      .kv_write       (kv_write),
      .kv_resp        (kv_resp)
   );

   kv_client client0 (
      .clk              (clk),
      .rst_n            (rst_n),
      .client_ctrl_reg  (ctrl),
      .kv_read          (kv_read),
      .kv_write         (kv_write),
      .kv_resp          (kv_resp),
      .key_write_en     (key_write_en),
      .key_write_offset (key_write_offset),
      .key_write_data   (key_write_data),
      .src_write_en     (src_write_en),
      .src_write_offset (src_write_offset),
      .src_write_data   (src_write_data),
      .dest_keyvault    (dest_keyvault),
      .dest_data_avail  (dest_data_avail),
      .dest_data        (dest_data),
      .key_done         (key_done),
      .src_done         (src_done),
      .dest_done        (dest_done)
   );

   kv_engine engine0 (
      .clk              (clk),
      .rst_n            (rst_n),
      .key_write_en     (key_write_en),
      .key_write_offset (key_write_offset),
      .key_write_data   (key_write_data),
      .src_write_en     (src_write_en),
      .src_write_offset (src_write_offset),
      .src_write_data   (src_write_data),
      .key_done         (key_done),
      .src_done         (src_done),
      .dest_keyvault    (dest_keyvault),
      .src_sel_en       (ctrl.src_sel_en),
      .dest_data_avail  (dest_data_avail),
      .dest_data        (dest_data),
      .result_valid     (result_valid),
      .result_data      (result_data)
   );

endmodule

`default_nettype wire

/* source/kv_engine.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kv_macros.svh"

module kv_engine (
   input  wire                                      clk,
   input  wire                                      rst_n,
   input  wire                                      key_write_en,
   input  wire kv_pkg::kv_offset_t                  key_write_offset,
   input  wire kv_pkg::kv_dword_t                   key_write_data,
   input  wire                                      src_write_en,
   input  wire kv_pkg::kv_offset_t                  src_write_offset,
   input  wire kv_pkg::kv_dword_t                   src_write_data,
   input  wire                                      key_done,
   input  wire                                      src_done,
   input  wire                                      dest_keyvault,
   input  wire                                      src_sel_en,
   output logic                                     dest_data_avail,
   output kv_pkg::kv_dword_t [`KV_ENTRY_DWORDS-1:0] dest_data,
   output logic                                     result_valid,
   output kv_pkg::kv_dword_t [`KV_ENTRY_DWORDS-1:0] result_data
);
   import kv_pkg::*;

   kv_dword_t [`KV_ENTRY_DWORDS-1:0] key_bank;
   kv_dword_t [`KV_ENTRY_DWORDS-1:0] src_bank;
   kv_dword_t [`KV_ENTRY_DWORDS-1:0] result_nxt;
   kv_dword_t [`KV_ENTRY_DWORDS-1:0] result_q;
   logic                             both_done;
   logic                             both_done_q;
   logic                             fire;

   // operand banks, one dword per strobe
   always_ff @(posedge clk) begin
      if (key_write_en) begin
         key_bank[key_write_offset] <= key_write_data;
      end
      if (src_write_en) begin
         src_bank[src_write_offset] <= src_write_data;
      end
   end

   // dword k lands at index 11-k
   always_comb begin
      for (int k = 0; k < `KV_ENTRY_DWORDS; k++) begin
         result_nxt[`KV_ENTRY_DWORDS-1-k] = key_bank[k] ^ src_bank[k];
      end
   end

   assign both_done = key_done & src_done;
   // only the first cycle both are done
   assign fire = both_done & ~both_done_q;

   always_ff @(posedge clk) begin
      if (fire) begin
         result_q <= result_nxt;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         both_done_q     <= 1'b0;
         dest_data_avail <= 1'b0;
         result_valid    <= 1'b0;
      end else begin
         both_done_q <= both_done;
         if (!src_sel_en) begin
            dest_data_avail <= 1'b0;
            result_valid    <= 1'b0;
         end else if (fire) begin
            // ready goes to the vault or to the host
            dest_data_avail <= dest_keyvault;
            result_valid    <= ~dest_keyvault;
         end
      end
   end

   assign dest_data   = result_q;
   assign result_data = result_q;

   a_one_ready_path: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(dest_data_avail && result_valid)
   );

endmodule

`default_nettype wire

/* source/kv_client.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kv_macros.svh"

module kv_client (
   input  wire                                           clk,
   input  wire                                           rst_n,
   input  wire kv_pkg::kv_reg_t                          client_ctrl_reg,
   output kv_pkg::kv_read_t                              kv_read,
   output kv_pkg::kv_write_t                             kv_write,
   input  wire kv_pkg::kv_resp_t                         kv_resp,
   output logic                                          key_write_en,
   output kv_pkg::kv_offset_t                            key_write_offset,
   output kv_pkg::kv_dword_t                             key_write_data,
   output logic                                          src_write_en,
   output kv_pkg::kv_offset_t                            src_write_offset,
   output kv_pkg::kv_dword_t                             src_write_data,
   output logic                                          dest_keyvault,
   input  wire                                           dest_data_avail,
   input  wire kv_pkg::kv_dword_t [`KV_ENTRY_DWORDS-1:0] dest_data,
   output logic                                          key_done,
   output logic                                          src_done,
   output logic                                          dest_done
);
   import kv_pkg::*;

   localparam kv_offset_t LAST_OFFSET = kv_offset_t'(`KV_ENTRY_DWORDS - 1);

   kv_offset_t key_read_offset;
   kv_offset_t src_read_offset;
   logic       src_write_pad;
   kv_dword_t  src_pad_data;
   kv_offset_t dest_read_offset;
   kv_offset_t dest_write_offset;
   logic       dest_write_en;
   kv_dword_t  dest_dword_q;

   // key read
   kv_fsm #(.PAD_EN(0)) key_fsm (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (client_ctrl_reg.key_sel_en),
      .data_size    ('0),
      .read_offset  (key_read_offset),
      .write_en     (key_write_en),
      .write_offset (key_write_offset),
      .write_pad    (),
      .pad_data     (),
      .done         (key_done)
   );

   assign key_write_data = kv_resp.key_data;

   // source read, short sources get padded
   kv_fsm #(.PAD_EN(1)) src_fsm (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (client_ctrl_reg.src_sel_en),
      .data_size    (client_ctrl_reg.src_data_size),
      .read_offset  (src_read_offset),
      .write_en     (src_write_en),
      .write_offset (src_write_offset),
      .write_pad    (src_write_pad),
      .pad_data     (src_pad_data),
      .done         (src_done)
   );

   assign src_write_data = src_write_pad ? src_pad_data : kv_resp.src_data;

   always_comb begin
      kv_read.key_entry  = client_ctrl_reg.key_sel;
      kv_read.key_offset = key_read_offset;
      kv_read.src_entry  = client_ctrl_reg.src_sel;
      kv_read.src_offset = src_read_offset;
   end

   // destination writeback, started once the engine has a result
   kv_fsm #(.PAD_EN(0)) dest_fsm (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (dest_data_avail & client_ctrl_reg.dest_sel_en),
      .data_size    ('0),
      .read_offset  (dest_read_offset),
      .write_en     (dest_write_en),
      .write_offset (dest_write_offset),
      .write_pad    (),
      .pad_data     (),
      .done         (dest_done)
   );

   // result dwords are stored reversed in dest_data
   always_ff @(posedge clk) begin
      dest_dword_q <= dest_data[LAST_OFFSET - dest_read_offset];
   end

   assign dest_keyvault = client_ctrl_reg.dest_sel_en;

   always_comb begin
      kv_write.dest_addr   = client_ctrl_reg.dest_sel;
      kv_write.dest_offset = dest_write_offset;
      kv_write.dest_wr_vld = dest_write_en;
      kv_write.dest_data   = dest_dword_q;
      kv_write.dest_valid  = client_ctrl_reg.dest_valid;
   end

endmodule

`default_nettype wire

/* source/kv_vault.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kv_macros.svh"

module kv_vault (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        host_wr_en,
   input  wire kv_pkg::kv_entry_idx_t host_wr_entry,
   input  wire kv_pkg::kv_offset_t    host_wr_offset,
   input  wire kv_pkg::kv_dword_t     host_wr_data,
   input  wire kv_pkg::kv_entry_idx_t host_rd_entry,
   input  wire kv_pkg::kv_offset_t    host_rd_offset,
   output kv_pkg::kv_dword_t          host_rd_data,
   input  wire kv_pkg::kv_read_t      kv_read,
   input  wire kv_pkg::kv_write_t     kv_write,
   output kv_pkg::kv_resp_t           kv_resp
);
   import kv_pkg::*;

   localparam kv_offset_t LAST_OFFSET = kv_offset_t'(`KV_ENTRY_DWORDS - 1);

   kv_dword_t                  mem [`KV_NUM_ENTRIES][`KV_ENTRY_DWORDS];
   logic [`KV_NUM_ENTRIES-1:0] entry_valid;

   // offsets past the entry read as zero
   function automatic kv_dword_t mem_word(kv_entry_idx_t entry, kv_offset_t offset);
      return (offset <= LAST_OFFSET) ? mem[entry][offset] : '0;
   endfunction

   function automatic kv_dword_t valid_word(kv_entry_idx_t entry, kv_offset_t offset);
      return entry_valid[entry] ? mem_word(entry, offset) : '0;
   endfunction

   // client write comes second so it wins a collision
   always_ff @(posedge clk) begin
      if (host_wr_en && (host_wr_offset <= LAST_OFFSET)) begin
         mem[host_wr_entry][host_wr_offset] <= host_wr_data;
      end
      if (kv_write.dest_wr_vld && (kv_write.dest_offset <= LAST_OFFSET)) begin
         mem[kv_write.dest_addr][kv_write.dest_offset] <= kv_write.dest_data;
      end
   end

   // entry becomes valid on its last dword
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         entry_valid <= '0;
      end else begin
         if (host_wr_en && (host_wr_offset == LAST_OFFSET)) begin
            entry_valid[host_wr_entry] <= 1'b1;
         end
         if (kv_write.dest_wr_vld && kv_write.dest_valid &&
             (kv_write.dest_offset == LAST_OFFSET)) begin
            entry_valid[kv_write.dest_addr] <= 1'b1;
         end
      end
   end

   // registered read ports
   always_ff @(posedge clk) begin
      kv_resp.key_data <= valid_word(kv_read.key_entry, kv_read.key_offset);
      kv_resp.src_data <= valid_word(kv_read.src_entry, kv_read.src_offset);
      host_rd_data     <= mem_word(host_rd_entry, host_rd_offset);
   end

   // host preload must not race a client writeback into one entry
   a_no_write_collision: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(host_wr_en && kv_write.dest_wr_vld && (host_wr_entry == kv_write.dest_addr))
   );

endmodule

`default_nettype wire

/* source/kv_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kv_macros.svh"

module kv_fsm #(
   parameter int PAD_EN = 0
) (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     start,
   input  wire kv_pkg::kv_offset_t data_size,
   output kv_pkg::kv_offset_t      read_offset,
   output logic                    write_en,
   output kv_pkg::kv_offset_t      write_offset,
   output logic                    write_pad,
   output kv_pkg::kv_dword_t       pad_data,
   output logic                    done
);
   import kv_pkg::*;

   localparam kv_offset_t LAST_OFFSET = kv_offset_t'(`KV_ENTRY_DWORDS - 1);

   kv_fsm_state_e state;
   kv_fsm_state_e state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (start) begin
               state_nxt = READ;
            end
         end
         READ: begin
            if (read_offset == LAST_OFFSET) begin
               state_nxt = FLUSH;
            end
         end
         // one extra cycle for the last write behind the read
         FLUSH: begin
            state_nxt = DONE;
         end
         DONE: begin
            if (!start) begin
               state_nxt = IDLE;
            end
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= IDLE;
         read_offset  <= '0;
         write_en     <= 1'b0;
         write_offset <= '0;
      end else begin
         state <= state_nxt;
         if ((state == READ) && (read_offset != LAST_OFFSET)) begin
            read_offset <= read_offset + kv_offset_t'(1);
         end else begin
            read_offset <= '0;
         end
         // writes trail reads by the vault read latency
         write_en     <= (state == READ);
         write_offset <= read_offset;
      end
   end

   assign done = (state == DONE);

   // pad rule: marker word at data_size, zeros after it
   always_comb begin
      write_pad = (PAD_EN != 0) && write_en && (write_offset >= data_size);
      pad_data  = (write_offset == data_size) ? `KV_PAD_WORD : '0;
   end

   a_write_offset_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      write_en |-> (write_offset <= LAST_OFFSET)
   );

endmodule

`default_nettype wire

/* source/kv_pkg.sv */
`default_nettype none

`include "kv_macros.svh"

package kv_pkg;

   typedef logic [31:0] kv_dword_t;
   typedef logic [`KV_ENTRY_W-1:0] kv_entry_idx_t;
   typedef logic [`KV_OFFSET_W-1:0] kv_offset_t;

   // client control, held stable by the host for a whole run
   typedef struct packed {
      logic          key_sel_en;
      kv_entry_idx_t key_sel;
      logic          src_sel_en;
      kv_entry_idx_t src_sel;
      // valid source dwords, the rest get padded
      kv_offset_t    src_data_size;
      logic          dest_sel_en;
      kv_entry_idx_t dest_sel;
      logic          dest_valid;
   } kv_reg_t;

   // client read request, answered one cycle later
   typedef struct packed {
      kv_entry_idx_t key_entry;
      kv_offset_t    key_offset;
      kv_entry_idx_t src_entry;
      kv_offset_t    src_offset;
   } kv_read_t;

   typedef struct packed {
      kv_entry_idx_t dest_addr;
      kv_offset_t    dest_offset;
      logic          dest_wr_vld;
      kv_dword_t     dest_data;
      // marks the entry valid on the last dword
      logic          dest_valid;
   } kv_write_t;

   typedef struct packed {
      kv_dword_t key_data;
      kv_dword_t src_data;
   } kv_resp_t;

   typedef enum logic [1:0] {
      IDLE,
      READ,
      FLUSH,
      DONE
   } kv_fsm_state_e;

endpackage

`default_nettype wire

/* source/kv_macros.svh */
`ifndef KV_MACROS_SVH
`define KV_MACROS_SVH

// vault geometry
`define KV_NUM_ENTRIES 8
`define KV_ENTRY_DWORDS 12

// index widths
`define KV_ENTRY_W 3
`define KV_OFFSET_W 4

// first dword written past the source size
// the dwords after it are zero
`define KV_PAD_WORD 32'h8000_0000

`endif
